//--- common/fp_pkg.sv
// Shared definitions for the half-precision adder
// Format widths, exponent bias and the all-ones exponent
// Bit positions in the packed word and in the total-form significand
// Effective operation type passed from decode to execute

package fp_pkg;

    ////////////////////
    // Packed format
    localparam int EXP_WIDTH  = 5;
    localparam int FRAC_WIDTH = 10;
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + FRAC_WIDTH;

    // Total form: carry, lead, fraction, round
    localparam int SIG_WIDTH  = FRAC_WIDTH + 3;

    ////////////////////
    // Exponent encoding
    localparam int EXP_BIAS = (1 << (EXP_WIDTH - 1)) - 1;
    // All ones, reserved for infinity
    localparam int EXP_MAX  = 2 * EXP_BIAS + 1;

    ////////////////////
    // Packed word bit positions
    localparam int SIGN_IDX     = FP_WIDTH - 1;
    localparam int EXP_IDX_MSB  = FP_WIDTH - 2;
    localparam int EXP_IDX_LSB  = FRAC_WIDTH;
    localparam int FRAC_IDX_MSB = FRAC_WIDTH - 1;

    // Total-form bit positions
    localparam int CARRY_IDX = SIG_WIDTH - 1;
    localparam int LEAD_IDX  = SIG_WIDTH - 2;
    localparam int ROUND_IDX = 0;

    ////////////////////
    // Effective operation
    // Equal signs add magnitudes, opposite signs subtract them
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

endpackage

//--- fp_adder/fp_align.sv
// Decode stage of the adder
// Unpacks both operands into total form
// Orders them by magnitude, aligns and rounds the smaller one
// Works out the effective operation from the signs

module fp_align (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [fp_pkg::FP_WIDTH-1:0]  fp_a_i,
    input  logic [fp_pkg::FP_WIDTH-1:0]  fp_b_i,
    input  logic                         valid_i,
    output logic                         big_sign_o,
    output logic [fp_pkg::EXP_WIDTH-1:0] big_exp_o,
    output logic [fp_pkg::SIG_WIDTH-1:0] big_sig_o,
    output logic [fp_pkg::SIG_WIDTH-1:0] small_sig_o,
    output fp_pkg::add_op_e              op_o,
    output logic                         valid_o
);
    import fp_pkg::*;

    ////////////////////
    // Input registers
    logic [FP_WIDTH-1:0] fp_a_r;
    logic [FP_WIDTH-1:0] fp_b_r;
    logic                valid_r;

    always_ff @(posedge clk_i) begin
        fp_a_r <= fp_a_i;
        fp_b_r <= fp_b_i;
        if (rst_i) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= valid_i;
        end
    end

    ////////////////////
    // Unpack helpers
    // Zero exponent means subnormal, effective exponent 1
    function automatic logic [EXP_WIDTH-1:0] eff_exp(input logic [FP_WIDTH-1:0] fp);
        logic [EXP_WIDTH-1:0] raw;
        raw = fp[EXP_IDX_MSB:EXP_IDX_LSB];
        return (raw == '0) ? EXP_WIDTH'(1) : raw;
    endfunction

    // Carry and round bits start out clear
    function automatic logic [SIG_WIDTH-1:0] total_sig(input logic [FP_WIDTH-1:0] fp);
        logic lead;
        lead = |fp[EXP_IDX_MSB:EXP_IDX_LSB];
        return {1'b0, lead, fp[FRAC_IDX_MSB:0], 1'b0};
    endfunction

    ////////////////////
    // Order and align
    logic [EXP_WIDTH-1:0] a_exp;
    logic [EXP_WIDTH-1:0] b_exp;
    logic [SIG_WIDTH-1:0] a_sig;
    logic [SIG_WIDTH-1:0] b_sig;
    logic                 swap;
    logic [EXP_WIDTH-1:0] small_exp;
    logic [SIG_WIDTH-1:0] small_sig;
    logic [EXP_WIDTH-1:0] exp_diff;
    logic [SIG_WIDTH-1:0] shifted;

    always_comb begin
        a_exp = eff_exp(fp_a_r);
        b_exp = eff_exp(fp_b_r);
        a_sig = total_sig(fp_a_r);
        b_sig = total_sig(fp_b_r);
        // Exponent first, significand breaks the tie
        swap = (b_exp > a_exp) || ((b_exp == a_exp) && (b_sig > a_sig));

        big_sign_o = swap ? fp_b_r[SIGN_IDX] : fp_a_r[SIGN_IDX];
        big_exp_o  = swap ? b_exp : a_exp;
        big_sig_o  = swap ? b_sig : a_sig;
        small_exp  = swap ? a_exp : b_exp;
        small_sig  = swap ? a_sig : b_sig;

        // Bits below the round position fall off
        exp_diff = big_exp_o - small_exp;
        if (exp_diff > EXP_WIDTH'(FRAC_WIDTH + 1)) begin
            shifted = '0;
        end else begin
            shifted = small_sig >> exp_diff;
        end

        // Half-up on the round bit
        small_sig_o = shifted + SIG_WIDTH'(shifted[ROUND_IDX]);
    end

    assign op_o    = (fp_a_r[SIGN_IDX] == fp_b_r[SIGN_IDX]) ? OP_ADD : OP_SUB;
    assign valid_o = valid_r;

    // Execute relies on this ordering for a non-negative difference
    // Packed magnitudes order the same way as the values
    a_big_first: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_r |-> (swap ? (fp_b_r[EXP_IDX_MSB:0] >= fp_a_r[EXP_IDX_MSB:0])
                          : (fp_a_r[EXP_IDX_MSB:0] >= fp_b_r[EXP_IDX_MSB:0])));

endmodule

//--- fp_adder/fp_add_core.sv
// Execute stage of the adder
// Sign-magnitude add or subtract of the aligned significands
// Result keeps the larger operand's sign and exponent

module fp_add_core (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         big_sign_i,
    input  logic [fp_pkg::EXP_WIDTH-1:0] big_exp_i,
    input  logic [fp_pkg::SIG_WIDTH-1:0] big_sig_i,
    input  logic [fp_pkg::SIG_WIDTH-1:0] small_sig_i,
    input  fp_pkg::add_op_e              op_i,
    input  logic                         valid_i,
    output logic                         res_sign_o,
    output logic [fp_pkg::EXP_WIDTH-1:0] res_exp_o,
    output logic [fp_pkg::SIG_WIDTH:0]   res_sig_o,
    output logic                         valid_o
);
    import fp_pkg::*;

    ////////////////////
    // Input registers
    logic                 big_sign_r;
    logic [EXP_WIDTH-1:0] big_exp_r;
    logic [SIG_WIDTH-1:0] big_sig_r;
    logic [SIG_WIDTH-1:0] small_sig_r;
    add_op_e              op_r;
    logic                 valid_r;

    always_ff @(posedge clk_i) begin
        big_sign_r  <= big_sign_i;
        big_exp_r   <= big_exp_i;
        big_sig_r   <= big_sig_i;
        small_sig_r <= small_sig_i;
        op_r        <= op_i;
        if (rst_i) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= valid_i;
        end
    end

    ////////////////////
    // Magnitude add or subtract
    logic [SIG_WIDTH:0] sum;

    always_comb begin
        if (op_r == OP_ADD) begin
            sum = {1'b0, big_sig_r} + {1'b0, small_sig_r};
        end else begin
            // Larger minus smaller, never negative
            sum = {1'b0, big_sig_r} - {1'b0, small_sig_r};
        end
    end

    // Exact cancellation gives +0
    assign res_sign_o = ((op_r == OP_SUB) && (sum == '0)) ? 1'b0 : big_sign_r;
    assign res_exp_o  = big_exp_r;
    assign res_sig_o  = sum;
    assign valid_o    = valid_r;

    // Ordering from decode must survive its alignment and rounding
    a_sub_order: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_r && (op_r == OP_SUB)) |-> (big_sig_r >= small_sig_r));

endmodule

//--- fp_adder/fp_normalize.sv
// Result stage of the adder
// Normalizes the raw sum, right by one or left by leading-one search
// Rounds half-up on the round bit
// Flushes underflow to +0, saturates overflow to signed infinity, packs

module fp_normalize (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         res_sign_i,
    input  logic [fp_pkg::EXP_WIDTH-1:0] res_exp_i,
    input  logic [fp_pkg::SIG_WIDTH:0]   res_sig_i,
    input  logic                         valid_i,
    output logic [fp_pkg::FP_WIDTH-1:0]  fp_o,
    output logic                         valid_o
);
    import fp_pkg::*;

    ////////////////////
    // Input registers
    logic                 sign_r;
    logic [EXP_WIDTH-1:0] exp_r;
    logic [SIG_WIDTH:0]   sig_r;
    logic                 valid_r;

    always_ff @(posedge clk_i) begin
        sign_r <= res_sign_i;
        exp_r  <= res_exp_i;
        sig_r  <= res_sig_i;
        if (rst_i) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= valid_i;
        end
    end

    ////////////////////
    // Normalize
    int                     lead_pos;
    int                     lshift;
    logic                   zero_res;
    logic [EXP_WIDTH+1:0]   norm_exp;
    logic [SIG_WIDTH-1:0]   norm_sig;
    // Rounded mantissa: carry out, lead, fraction
    logic [FRAC_WIDTH+1:0]  mant;
    logic [EXP_WIDTH+1:0]   rnd_exp;
    logic [FP_WIDTH-1:0]    fp_res;

    always_comb begin
        // Highest set bit at or below the lead position
        lead_pos = 0;
        for (int i = 0; i <= LEAD_IDX; i++) begin
            if (sig_r[i]) begin
                lead_pos = i;
            end
        end
        lshift = LEAD_IDX - lead_pos;

        zero_res = 1'b0;
        norm_exp = {2'b00, exp_r};
        norm_sig = sig_r[SIG_WIDTH-1:0];
        if (|sig_r[SIG_WIDTH:CARRY_IDX]) begin
            // Carry out of the add, one step right
            norm_sig = sig_r[SIG_WIDTH:1];
            norm_exp = norm_exp + 1'b1;
        end else if ((sig_r == '0) || (lshift >= int'(exp_r))) begin
            // Zero, or exponent would drop below 1
            zero_res = 1'b1;
        end else begin
            norm_sig = sig_r[SIG_WIDTH-1:0] << lshift;
            norm_exp = norm_exp - (EXP_WIDTH + 2)'(lshift);
        end

        ////////////////////
        // Round half-up
        mant    = {1'b0, norm_sig[LEAD_IDX:1]} + (FRAC_WIDTH + 2)'(norm_sig[ROUND_IDX]);
        rnd_exp = norm_exp;
        if (mant[FRAC_WIDTH+1]) begin
            // All-ones mantissa rolled over
            mant    = mant >> 1;
            rnd_exp = rnd_exp + 1'b1;
        end

        ////////////////////
        // Pack
        if (zero_res) begin
            fp_res = '0;
        end else if (rnd_exp >= (EXP_WIDTH + 2)'(EXP_MAX)) begin
            // Out of range, signed infinity
            fp_res = {sign_r, EXP_WIDTH'(EXP_MAX), {FRAC_WIDTH{1'b0}}};
        end else begin
            // Lead bit stays hidden
            fp_res = {sign_r, rnd_exp[EXP_WIDTH-1:0], mant[FRAC_WIDTH-1:0]};
        end
    end

    assign fp_o    = fp_res;
    assign valid_o = valid_r;

    // Strobe must be clean once the whole chain has left reset
    a_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(valid_o));

endmodule

//--- fp_adder/fp_adder_top.sv
// Top level of the three-stage half-precision adder
// Decode, execute and result stages in a chain
// Fixed latency of three cycles, one pair accepted per cycle

module fp_adder_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [fp_pkg::FP_WIDTH-1:0] fp_a_i,
    input  logic [fp_pkg::FP_WIDTH-1:0] fp_b_i,
    input  logic                        valid_i,
    output logic [fp_pkg::FP_WIDTH-1:0] fp_o,
    output logic                        valid_o
);
    import fp_pkg::*;

    ////////////////////
    // Decode to execute
    logic                 big_sign;
    logic [EXP_WIDTH-1:0] big_exp;
    logic [SIG_WIDTH-1:0] big_sig;
    logic [SIG_WIDTH-1:0] small_sig;
    add_op_e              op;
    logic                 align_valid;

    // Execute to result
    logic                 res_sign;
    logic [EXP_WIDTH-1:0] res_exp;
    logic [SIG_WIDTH:0]   res_sig;
    logic                 core_valid;

    fp_align i_fp_align (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .fp_a_i      (fp_a_i),
        .fp_b_i      (fp_b_i),
        .valid_i     (valid_i),
        .big_sign_o  (big_sign),
        .big_exp_o   (big_exp),
        .big_sig_o   (big_sig),
        .small_sig_o (small_sig),
        .op_o        (op),
        .valid_o     (align_valid)
    );

    fp_add_core i_fp_add_core (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .big_sign_i  (big_sign),
        .big_exp_i   (big_exp),
        .big_sig_i   (big_sig),
        .small_sig_i (small_sig),
        .op_i        (op),
        .valid_i     (align_valid),
        .res_sign_o  (res_sign),
        .res_exp_o   (res_exp),
        .res_sig_o   (res_sig),
        .valid_o     (core_valid)
    );

    fp_normalize i_fp_normalize (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .res_sign_i (res_sign),
        .res_exp_i  (res_exp),
        .res_sig_i  (res_sig),
        .valid_i    (core_valid),
        .fp_o       (fp_o),
        .valid_o    (valid_o)
    );

endmodule

//--- bench/tb_fp_adder.sv
// Random testbench for the three-stage half-precision adder
// LFSR stimulus with gaps, integer reference model
// Scoreboard queue with latency check, watchdog

module tb_fp_adder;
    timeunit 1ns;
    timeprecision 1ps;
    import fp_pkg::*;

    localparam int NUM_TESTS  = 2000;
    localparam int CLK_PERIOD = 10;
    localparam int LATENCY    = 3;
    // Four cycles per pair plus room for reset and drain
    localparam int TIMEOUT_NS = (NUM_TESTS * 4 + 50) * CLK_PERIOD;

    logic                clk_i;
    logic                rst_i;
    logic [FP_WIDTH-1:0] fp_a_i;
    logic [FP_WIDTH-1:0] fp_b_i;
    logic                valid_i;
    logic [FP_WIDTH-1:0] fp_o;
    logic                valid_o;

    logic [15:0]           lfsr;
    int                    cycle = 0;
    int                    errors = 0;
    int                    checked = 0;
    // Entries hold operand a, operand b, expected sum
    logic [3*FP_WIDTH-1:0] exp_q[$];
    int                    due_q[$];

    fp_adder_top i_fp_adder_top (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .fp_a_i  (fp_a_i),
        .fp_b_i  (fp_b_i),
        .valid_i (valid_i),
        .fp_o    (fp_o),
        .valid_o (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Zeros, subnormals, near-overflow and plain normals; exponent never all ones
    function automatic logic [FP_WIDTH-1:0] rand_operand();
        logic [2:0]            kind;
        logic                  sign;
        logic [EXP_WIDTH-1:0]  e;
        logic [FRAC_WIDTH-1:0] frac;
        kind = 3'(take_bits(3));
        sign = 1'(take_bits(1));
        frac = FRAC_WIDTH'(take_bits(FRAC_WIDTH));
        e    = EXP_WIDTH'(take_bits(EXP_WIDTH) % (EXP_MAX - 1) + 1);
        if (kind == 3'd0) begin
            e    = '0;
            frac = '0;
        end else if (kind == 3'd1) begin
            e = '0;
        end else if (kind == 3'd2) begin
            e = EXP_WIDTH'(EXP_MAX - 1 - take_bits(1));
        end
        return {sign, e, frac};
    endfunction

    ////////////////////
    // Reference model on integers
    // Significand held as mantissa times two, round bit at the bottom
    function automatic logic [FP_WIDTH-1:0] model_add(input logic [FP_WIDTH-1:0] a,
                                                      input logic [FP_WIDTH-1:0] b);
        int ea, eb, ma, mb;
        int sa, sb, sign, e, d;
        int big_m, small_m, sum, mant;
        ea = int'(a[FP_WIDTH-2:FRAC_WIDTH]);
        eb = int'(b[FP_WIDTH-2:FRAC_WIDTH]);
        ma = 2 * (((ea != 0) ? (1 << FRAC_WIDTH) : 0) + int'(a[FRAC_WIDTH-1:0]));
        mb = 2 * (((eb != 0) ? (1 << FRAC_WIDTH) : 0) + int'(b[FRAC_WIDTH-1:0]));
        // Subnormals sit at exponent 1
        ea = (ea == 0) ? 1 : ea;
        eb = (eb == 0) ? 1 : eb;
        sa = int'(a[FP_WIDTH-1]);
        sb = int'(b[FP_WIDTH-1]);
        if ((eb > ea) || ((eb == ea) && (mb > ma))) begin
            e       = eb;
            sign    = sb;
            big_m   = mb;
            small_m = ma;
            d       = eb - ea;
        end else begin
            e       = ea;
            sign    = sa;
            big_m   = ma;
            small_m = mb;
            d       = ea - eb;
        end
        // Align, drop bits below the round bit, round half-up
        small_m = (d > FRAC_WIDTH + 1) ? 0 : (small_m >> d);
        small_m = small_m + (small_m & 1);
        sum = (sa == sb) ? (big_m + small_m) : (big_m - small_m);
        if (sum == 0) begin
            return '0;
        end
        if (sum >= (4 << FRAC_WIDTH)) begin
            sum = sum >> 1;
            e   = e + 1;
        end else begin
            while (sum < (2 << FRAC_WIDTH)) begin
                sum = sum * 2;
                e   = e - 1;
            end
            // Underflow flushes to +0
            if (e < 1) begin
                return '0;
            end
        end
        mant = (sum >> 1) + (sum & 1);
        if (mant >= (2 << FRAC_WIDTH)) begin
            mant = mant >> 1;
            e    = e + 1;
        end
        if (e >= EXP_MAX) begin
            return {sign[0], EXP_WIDTH'(EXP_MAX), {FRAC_WIDTH{1'b0}}};
        end
        return {sign[0], e[EXP_WIDTH-1:0], mant[FRAC_WIDTH-1:0]};
    endfunction

    ////////////////////
    // Scoreboard, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_i && (valid_o !== 1'b0)) begin
            $display("Mismatch: valid_o = %h during reset, expected 0", valid_o);
            errors++;
        end
        if (!rst_i && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Error: valid_o at cycle %0d without a matching input", cycle);
                errors++;
            end else begin
                if (due_q[0] != cycle) begin
                    $display("Error: result at cycle %0d, due at cycle %0d", cycle, due_q[0]);
                    errors++;
                end
                if (fp_o !== exp_q[0][FP_WIDTH-1:0]) begin
                    $display("Mismatch: fp_o = %h, expected %h (a %h, b %h)", fp_o,
                             exp_q[0][FP_WIDTH-1:0], exp_q[0][3*FP_WIDTH-1:2*FP_WIDTH],
                             exp_q[0][2*FP_WIDTH-1:FP_WIDTH]);
                    errors++;
                end
                checked++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
        if (!rst_i && valid_i) begin
            exp_q.push_back({fp_a_i, fp_b_i, model_add(fp_a_i, fp_b_i)});
            due_q.push_back(cycle + LATENCY);
        end
    end

    ////////////////////
    // Stimulus
    initial begin
        logic [FP_WIDTH-1:0] a;
        logic [FP_WIDTH-1:0] b;
        logic [2:0]          pick;
        int                  sent;
        lfsr    = 16'd29;
        sent    = 0;
        rst_i   = 1'b1;
        // Pairs offered during reset must be dropped
        valid_i = 1'b1;
        fp_a_i  = '0;
        fp_b_i  = '0;
        repeat (2) @(posedge clk_i);
        rst_i   <= 1'b0;
        valid_i <= 1'b0;
        while (sent < NUM_TESTS) begin
            @(posedge clk_i);
            // About three cycles in four carry a pair
            if (take_bits(2) != 0) begin
                a    = rand_operand();
                pick = 3'(take_bits(3));
                if (pick == 3'd0) begin
                    // Exact cancellation
                    b = {~a[FP_WIDTH-1], a[FP_WIDTH-2:0]};
                end else if (pick == 3'd1) begin
                    b = {~a[FP_WIDTH-1], a[FP_WIDTH-2:3], 3'(take_bits(3))};
                end else begin
                    b = rand_operand();
                end
                fp_a_i  <= a;
                fp_b_i  <= b;
                valid_i <= 1'b1;
                sent++;
            end else begin
                valid_i <= 1'b0;
            end
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        // A few idle cycles to catch a stray valid_o
        repeat (LATENCY + 2) @(posedge clk_i);
        $display("Results checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Error: simulation timed out with %0d results still pending", exp_q.size());
        $display("Results checked: %0d, errors: %0d", checked, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- all.f
common/fp_pkg.sv
fp_adder/fp_align.sv
fp_adder/fp_add_core.sv
fp_adder/fp_normalize.sv
fp_adder/fp_adder_top.sv
bench/tb_fp_adder.sv

//--- run.sh
#!/bin/sh
# Build and run the half-precision adder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_fp_adder \
    -o sim_fp_adder

./obj_dir/sim_fp_adder > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
